// File: vector_cosine_top.f
source/cosine_pkg.sv
source/dot_norm_accumulator.sv
source/sums_fifo.sv
source/cos_sq_divider.sv
source/vector_cosine_top.sv
testbench/tb_vector_cosine.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vector_cosine
FILELIST  ?= vector_cosine_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass only when the log holds the pass line
run: compile
	./$(SIM_BIN) | tee $(LOG)
	grep -q "Finished with no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: testbench/tb_vector_cosine.sv
`timescale 1ns/1ps
// Directed tests for the cosine similarity subsystem
// Expected results come from exact integer sums in a reference model
// Results are checked at the falling edge, inputs change 2 ns after the rising edge
// A wait that runs out stops the remaining tests

module tb_vector_cosine;
  import cosine_pkg::*;

  localparam int FRAC_W         = 16;
  localparam int FIFO_DEPTH     = 4;
  localparam int timeout_cycles = 200;

  logic        CLK;
  logic        RST;
  logic        START;
  run_cfg_t    cfg;
  logic        elem_valid;
  elem_pair_t  elem;
  logic        result_valid;
  cos_result_t result;
  logic        ready;

  // Elements of the vector being sent
  elem_pair_t  pairs [16];
  cos_result_t exp_q [$];
  logic        last_q [$];
  integer      seed;
  int          errors;
  int          got_count;
  int          test_base;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  vector_cosine_top #(
    .FRAC_W     (FRAC_W),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) uut (
    .CLK          (CLK),
    .RST          (RST),
    .START        (START),
    .cfg          (cfg),
    .elem_valid   (elem_valid),
    .elem         (elem),
    .result_valid (result_valid),
    .result       (result),
    .ready        (ready)
  );

  always #10 CLK = ~CLK;

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_result(input cos_result_t got, input cos_result_t exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: result idx %0d neg %0b zero %0b cos_sq %0d", $time,
               got.index, got.negative, got.zero, got.cos_sq);
      $display("  expected idx %0d neg %0b zero %0b cos_sq %0d",
               exp.index, exp.negative, exp.zero, exp.cos_sq);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Exact sums, then floor(dot^2 * 2^FRAC_W / (norm_a * norm_b))
  task automatic model_vector(input int index, input bit last, input int length);
    longint          dot;
    longint          na;
    longint          nb;
    longint unsigned q;
    cos_result_t     exp;
    dot = 0;
    na  = 0;
    nb  = 0;
    for (int i = 0; i < length; i++) begin
      dot += longint'(pairs[i].a) * longint'(pairs[i].b);
      na  += longint'(pairs[i].a) * longint'(pairs[i].a);
      nb  += longint'(pairs[i].b) * longint'(pairs[i].b);
    end
    exp          = '0;
    exp.index    = len_t'(index);
    exp.negative = (dot < 0);
    exp.zero     = (na == 0) || (nb == 0);
    if (!exp.zero) begin
      q          = (longint'(dot * dot) << FRAC_W) / longint'(na * nb);
      exp.cos_sq = q[cos_w-1:0];
    end
    exp_q.push_back(exp);
    last_q.push_back(last);
  endtask

  // Every result is matched against the head of the expected queue
  always @(negedge CLK) begin
    if (!RST) begin
      if (result_valid) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("ERROR: result with index %0d arrived when none was expected at %0t",
                   result.index, $time);
        end else begin
          check_result(result, exp_q.pop_front());
          check_flag("ready", ready, last_q.pop_front());
        end
        got_count++;
      end else begin
        check_flag("ready without result_valid", ready, 1'b0);
      end
    end
  end

  //////////////////////////////
  // Drivers and waits
  //////////////////////////////

  task automatic apply_reset();
    #2;
    RST        = 1'b1;
    START      = 1'b0;
    elem_valid = 1'b0;
    exp_q.delete();
    last_q.delete();
    repeat (4) @(posedge CLK);
    #2 RST = 1'b0;
  endtask

  task automatic set_pair(input int i, input int a, input int b);
    pairs[i].a = elem_t'(a);
    pairs[i].b = elem_t'(b);
  endtask

  task automatic fill_random(input int length);
    logic [31:0] r;
    for (int i = 0; i < length; i++) begin
      r          = $random(seed);
      pairs[i].a = r[7:0];
      pairs[i].b = r[15:8];
    end
  endtask

  // START pulse, cleared by the first element
  task automatic drive_start(input int count, input int length);
    @(posedge CLK);
    #2;
    START              = 1'b1;
    cfg.vector_count   = len_t'(count);
    cfg.vector_length  = len_t'(length);
  endtask

  // No gap between elements, nor between vectors
  task automatic send_vector(input int length);
    for (int i = 0; i < length; i++) begin
      @(posedge CLK);
      #2;
      START      = 1'b0;
      elem_valid = 1'b1;
      elem       = pairs[i];
    end
  endtask

  task automatic end_strobe();
    @(posedge CLK);
    #2;
    START      = 1'b0;
    elem_valid = 1'b0;
    elem       = '0;
  endtask

  // Timeout restarts with each result that comes in
  task automatic wait_results(input int target);
    int idle_cycles;
    int last_seen;
    idle_cycles = 0;
    last_seen   = got_count;
    while (got_count < target && idle_cycles < timeout_cycles) begin
      @(posedge CLK);
      if (got_count != last_seen) begin
        last_seen   = got_count;
        idle_cycles = 0;
      end else begin
        idle_cycles++;
      end
    end
    if (got_count < target) begin
      errors++;
      timed_out = 1'b1;
      $display("ERROR: timed out waiting for result at %0t", $time);
    end
  endtask

  task automatic begin_test();
    test_base   = got_count;
    test_errors = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
      $display("Test %0d %s: FAIL", tests_run, name);
    end else begin
      $display("Test %0d %s: PASS", tests_run, name);
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_identical();
    begin_test();
    set_pair(0, 10, 10);
    set_pair(1, -20, -20);
    set_pair(2, 30, 30);
    set_pair(3, 127, 127);
    drive_start(1, 4);
    model_vector(0, 1'b1, 4);
    send_vector(4);
    end_strobe();
    wait_results(test_base + 1);
    end_test("identical vectors");
  endtask

  // Vector 0 is b = -a, vector 1 is orthogonal
  task automatic test_sign_orthogonal();
    begin_test();
    drive_start(2, 4);
    set_pair(0, 1, -1);
    set_pair(1, -5, 5);
    set_pair(2, 9, -9);
    set_pair(3, 100, -100);
    model_vector(0, 1'b0, 4);
    send_vector(4);
    set_pair(0, 1, 4);
    set_pair(1, 2, -2);
    set_pair(2, 3, 0);
    set_pair(3, 4, 0);
    model_vector(1, 1'b1, 4);
    send_vector(4);
    end_strobe();
    wait_results(test_base + 2);
    end_test("sign and orthogonality");
  endtask

  task automatic test_zero_norm();
    begin_test();
    for (int i = 0; i < 4; i++) begin
      set_pair(i, 0, 5 + i);
    end
    drive_start(1, 4);
    model_vector(0, 1'b1, 4);
    send_vector(4);
    end_strobe();
    wait_results(test_base + 1);
    end_test("zero norm");
  endtask

  task automatic test_multi_vector();
    begin_test();
    drive_start(6, 16);
    for (int v = 0; v < 6; v++) begin
      fill_random(16);
      model_vector(v, v == 5, 16);
      send_vector(16);
    end
    end_strobe();
    wait_results(test_base + 6);
    end_test("multi-vector run");
  endtask

  // Length-1 vectors push every cycle, faster than the divider drains
  task automatic test_burst();
    int burst_a [4] = '{7, -8, 0, -128};
    int burst_b [4] = '{3, 2, 9, -128};
    begin_test();
    drive_start(4, 1);
    for (int v = 0; v < 4; v++) begin
      set_pair(0, burst_a[v], burst_b[v]);
      model_vector(v, v == 3, 1);
      send_vector(1);
    end
    end_strobe();
    wait_results(test_base + 4);
    end_test("buffering burst");
  endtask

  task automatic test_idle_reset();
    begin_test();
    apply_reset();
    @(negedge CLK);
    check_flag("result_valid after reset", result_valid, 1'b0);
    check_flag("ready after reset", ready, 1'b0);
    // No START, so these are dropped
    fill_random(5);
    send_vector(5);
    end_strobe();
    for (int i = 0; i < timeout_cycles; i++) begin
      @(posedge CLK);
    end
    if (got_count != test_base) begin
      errors++;
      $display("ERROR: elements strobed while idle produced a result");
    end
    end_test("ignored input and reset state");
  endtask

  initial begin
    CLK          = 1'b0;
    RST          = 1'b1;
    START        = 1'b0;
    cfg          = '0;
    elem_valid   = 1'b0;
    elem         = '0;
    seed         = 32'hc9e8150c;
    errors       = 0;
    got_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    timed_out    = 1'b0;
    apply_reset();
    if (!timed_out) test_identical();
    if (!timed_out) test_sign_orthogonal();
    if (!timed_out) test_zero_norm();
    if (!timed_out) test_multi_vector();
    if (!timed_out) test_burst();
    if (!timed_out) test_idle_reset();
    $display("Tests run: %0d, tests failed: %0d, errors: %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: source/vector_cosine_top.sv
`timescale 1ns/1ps
// Cosine similarity subsystem: accumulator, FIFO of per-vector sums, divider
// Source may run at most FIFO_DEPTH vectors ahead of the divider
// result_valid trails the last element of a vector by FRAC_W+5 cycles when unqueued

module vector_cosine_top #(
  parameter int FRAC_W     = 16,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    START,
  input  cosine_pkg::run_cfg_t    cfg,
  input  logic                    elem_valid,
  input  cosine_pkg::elem_pair_t  elem,
  output logic                    result_valid,
  output cosine_pkg::cos_result_t result,
  output logic                    ready
);
  import cosine_pkg::*;

  logic         push;
  vector_sums_t sums_in;
  vector_sums_t sums_out;
  logic         not_empty;
  logic         pop;

  //////////////////////////////
  // Producer
  //////////////////////////////

  dot_norm_accumulator u_acc (
    .CLK        (CLK),
    .RST        (RST),
    .START      (START),
    .cfg        (cfg),
    .elem_valid (elem_valid),
    .elem       (elem),
    .push       (push),
    .sums_in    (sums_in)
  );

  // Buffer
  sums_fifo #(
    .payload_t  (vector_sums_t),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .data_in   (sums_in),
    .pop       (pop),
    .data_out  (sums_out),
    .not_empty (not_empty)
  );

  // Consumer
  cos_sq_divider #(
    .FRAC_W (FRAC_W)
  ) u_div (
    .CLK          (CLK),
    .RST          (RST),
    .not_empty    (not_empty),
    .sums         (sums_out),
    .pop          (pop),
    .result_valid (result_valid),
    .result       (result),
    .ready        (ready)
  );

endmodule

// File: source/cos_sq_divider.sv
`timescale 1ns/1ps
// Squared cosine by restoring division, one quotient bit per cycle
// Fixed latency of FRAC_W+3 cycles from pop to result_valid, zero norms included
// One item in flight; FRAC_W from 8 to 16

module cos_sq_divider #(
  parameter int FRAC_W = 16
) (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     not_empty,
  input  cosine_pkg::vector_sums_t sums,
  output logic                     pop,
  output logic                     result_valid,
  output cosine_pkg::cos_result_t  result,
  output logic                     ready
);
  import cosine_pkg::*;

  localparam int q_w    = FRAC_W + 1;
  localparam int prod_w = 2 * sum_w;
  localparam int rem_w  = prod_w + 1;
  localparam int step_w = $clog2(FRAC_W + 1);

  typedef enum logic [1:0] {st_idle, st_divide, st_done} state_t;

  state_t                   state;
  logic [step_w-1:0]        step_q;
  logic signed [prod_w-1:0] dot_sq;
  logic [prod_w-1:0]        norm_prod;
  logic [rem_w-1:0]         rem_q;
  logic [rem_w-1:0]         rem_sub;
  logic [prod_w-1:0]        divisor_q;
  logic [q_w-1:0]           quot_q;
  logic                     ge;
  len_t                     index_q;
  logic                     last_q;
  logic                     negative_q;
  logic                     zero_q;

  if (FRAC_W < 8 || FRAC_W > frac_w_max) begin : g_frac_check
    $error("FRAC_W out of range");
  end

  //////////////////////////////
  // Operands and one step
  //////////////////////////////

  assign pop = (state == st_idle) && not_empty;

  // Squares fit since |dot| stays below 2^19
  assign dot_sq    = sums.dot * sums.dot;
  assign norm_prod = sums.norm_a * sums.norm_b;

  // dot^2 <= norm_a*norm_b, so the first bit is the integer part
  assign ge      = (rem_q >= {1'b0, divisor_q});
  assign rem_sub = ge ? rem_q - {1'b0, divisor_q} : rem_q;

  //////////////////////////////
  // Control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state        <= st_idle;
      step_q       <= '0;
      result_valid <= 1'b0;
      ready        <= 1'b0;
    end else begin
      result_valid <= 1'b0;
      ready        <= 1'b0;
      case (state)
        st_idle: begin
          if (pop) begin
            state  <= st_divide;
            step_q <= '0;
          end
        end
        st_divide: begin
          // FRAC_W+1 steps, integer bit first
          if (step_q == step_w'(FRAC_W)) begin
            state <= st_done;
          end else begin
            step_q <= step_q + 1'b1;
          end
        end
        st_done: begin
          result_valid <= 1'b1;
          ready        <= last_q;
          state        <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // Datapath, the FRAC_W shift of dot^2 is applied one bit per step
  always_ff @(posedge CLK) begin
    case (state)
      st_idle: begin
        if (pop) begin
          index_q    <= sums.index;
          last_q     <= sums.last;
          negative_q <= sums.dot[sum_w-1];
          zero_q     <= (sums.norm_a == '0) || (sums.norm_b == '0);
          rem_q      <= {1'b0, dot_sq};
          divisor_q  <= norm_prod;
          quot_q     <= '0;
        end
      end
      st_divide: begin
        rem_q  <= {rem_sub[rem_w-2:0], 1'b0};
        quot_q <= {quot_q[q_w-2:0], ge};
      end
      st_done: begin
        result.index    <= index_q;
        result.negative <= negative_q;
        result.zero     <= zero_q;
        // Quotient is meaningless with a zero divisor
        result.cos_sq   <= zero_q ? '0 : cos_w'(quot_q);
      end
      default: begin
      end
    endcase
  end

  // Result out a fixed time after each pop
  pop_latency_a: assert property (@(posedge CLK) disable iff (RST)
    pop |-> ##(FRAC_W + 3) result_valid);

endmodule

// File: source/sums_fifo.sv
`timescale 1ns/1ps
// Show-ahead FIFO, payload type and depth set by the instantiating block
// FIFO_DEPTH must be a power of two, 2 or more
// Push while full is dropped and flagged; nothing stalls the producer

module sums_fifo #(
  parameter type payload_t  = logic [7:0],
  parameter int  FIFO_DEPTH = 4
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     push,
  input  payload_t data_in,
  input  logic     pop,
  output payload_t data_out,
  output logic     not_empty
);

  localparam int ptr_w = $clog2(FIFO_DEPTH);

  payload_t         mem [FIFO_DEPTH];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0]   count;
  logic             full;
  logic             wr_en;
  logic             rd_en;

  assign full      = (count == (ptr_w + 1)'(FIFO_DEPTH));
  assign not_empty = (count != '0);
  assign wr_en     = push && !full;
  assign rd_en     = pop && not_empty;

  // Head of queue is always on the output
  assign data_out = mem[rd_ptr];

  // Storage
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_ptr] <= data_in;
    end
  end

  // Pointers wrap on their own width
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Producer ran more than FIFO_DEPTH items ahead of the consumer
  overflow_a: assert property (@(posedge CLK) disable iff (RST) push |-> !full);
  underflow_a: assert property (@(posedge CLK) disable iff (RST) pop |-> not_empty);

endmodule

// File: source/dot_norm_accumulator.sv
`timescale 1ns/1ps
// Sums a.b, a.a and b.b over each vector of a run and pushes them to the FIFO
// Elements are taken only between START and the last element of the run
// No back-pressure; the source keeps to the FIFO pacing contract
// START during a run is ignored and flagged

module dot_norm_accumulator (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     START,
  input  cosine_pkg::run_cfg_t     cfg,
  input  logic                     elem_valid,
  input  cosine_pkg::elem_pair_t   elem,
  output logic                     push,
  output cosine_pkg::vector_sums_t sums_in
);
  import cosine_pkg::*;

  localparam int prod_w = 2 * elem_w;

  logic                     busy;
  run_cfg_t                 cfg_q;
  len_t                     elem_cnt;
  len_t                     vec_cnt;
  dot_t                     dot_acc;
  norm_t                    norm_a_acc;
  norm_t                    norm_b_acc;
  logic signed [prod_w-1:0] prod_ab;
  logic signed [prod_w-1:0] prod_aa;
  logic signed [prod_w-1:0] prod_bb;
  dot_t                     dot_next;
  norm_t                    norm_a_next;
  norm_t                    norm_b_next;
  logic                     take;
  logic                     last_elem;
  logic                     last_vec;

  //////////////////////////////
  // Products and next sums
  //////////////////////////////

  assign take      = busy && elem_valid;
  assign last_elem = (elem_cnt == cfg_q.vector_length - 1'b1);
  assign last_vec  = (vec_cnt == cfg_q.vector_count - 1'b1);

  assign prod_ab = elem.a * elem.b;
  assign prod_aa = elem.a * elem.a;
  assign prod_bb = elem.b * elem.b;

  // Dot product sign-extended, squares are never negative
  assign dot_next    = dot_acc + {{(sum_w - prod_w){prod_ab[prod_w-1]}}, prod_ab};
  assign norm_a_next = norm_a_acc + {{(sum_w - prod_w){1'b0}}, prod_aa};
  assign norm_b_next = norm_b_acc + {{(sum_w - prod_w){1'b0}}, prod_bb};

  //////////////////////////////
  // Run control
  //////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy     <= 1'b0;
      elem_cnt <= '0;
      vec_cnt  <= '0;
      push     <= 1'b0;
    end else begin
      push <= 1'b0;
      if (START && !busy) begin
        busy     <= 1'b1;
        elem_cnt <= '0;
        vec_cnt  <= '0;
      end else if (take) begin
        if (last_elem) begin
          // Vector done, sums go out next cycle
          push     <= 1'b1;
          elem_cnt <= '0;
          vec_cnt  <= vec_cnt + 1'b1;
          if (last_vec) begin
            busy <= 1'b0;
          end
        end else begin
          elem_cnt <= elem_cnt + 1'b1;
        end
      end
    end
  end

  // Accumulators and outgoing sums
  always_ff @(posedge CLK) begin
    if (START && !busy) begin
      cfg_q      <= cfg;
      dot_acc    <= '0;
      norm_a_acc <= '0;
      norm_b_acc <= '0;
    end else if (take) begin
      if (last_elem) begin
        sums_in.index  <= vec_cnt;
        sums_in.last   <= last_vec;
        sums_in.dot    <= dot_next;
        sums_in.norm_a <= norm_a_next;
        sums_in.norm_b <= norm_b_next;
        // Fresh start for the next vector
        dot_acc    <= '0;
        norm_a_acc <= '0;
        norm_b_acc <= '0;
      end else begin
        dot_acc    <= dot_next;
        norm_a_acc <= norm_a_next;
        norm_b_acc <= norm_b_next;
      end
    end
  end

  // Source must wait for the last vector of a run before the next START
  start_idle_a: assert property (@(posedge CLK) disable iff (RST) START |-> !busy);

endmodule

// File: source/cosine_pkg.sv
// Widths and payload structs shared by the cosine similarity blocks
// Vector counts and lengths run from 1 to 16; all sums are exact integers
// cos_sq is sized for the widest fraction; narrower builds zero its top bits

package cosine_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Signed input element
  localparam int elem_w = 8;
  // Count and length fields, values 1 to 16
  localparam int len_w = 5;
  // 16 products of two 8-bit values fit with margin
  localparam int sum_w = 20;
  // Upper limit for FRAC_W of the divider
  localparam int frac_w_max = 16;
  localparam int cos_w = frac_w_max + 1;

  //////////////////////////////
  // Scalar types
  //////////////////////////////

  typedef logic [len_w-1:0] len_t;
  typedef logic signed [elem_w-1:0] elem_t;
  typedef logic signed [sum_w-1:0] dot_t;
  // Norm sums are never negative
  typedef logic [sum_w-1:0] norm_t;

  //////////////////////////////
  // Structs
  //////////////////////////////

  // One element pair per strobe
  typedef struct packed {
    elem_t a;
    elem_t b;
  } elem_pair_t;

  // Latched at START
  typedef struct packed {
    len_t vector_count;
    len_t vector_length;
  } run_cfg_t;

  // Per-vector sums, accumulator to divider
  typedef struct packed {
    len_t  index;
    logic  last;
    dot_t  dot;
    norm_t norm_a;
    norm_t norm_b;
  } vector_sums_t;

  // Squared cosine as unsigned fraction, sign carried apart
  typedef struct packed {
    len_t             index;
    logic             negative;
    logic             zero;
    logic [cos_w-1:0] cos_sq;
  } cos_result_t;

endpackage
